// ==== execStage.f ====
logic/mipsExecPkg.sv
logic/functDecoder.sv
logic/aluCore.sv
logic/mulDivUnit.sv
logic/resultStage.sv
logic/execStage.sv
sim/execStageChecker.sv
sim/execStage_chk.sv
sim/execStageTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the execStage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f execStage.f --top-module execStageTb -o execStageSim

./obj_dir/execStageSim > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0

// ==== sim/execStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module execStageTb;

    // shifts, moves, mult/div, alu ops, one unknown code
    localparam mipsExecPkg::funct_t functList [0:21] = '{
        mipsExecPkg::functSll, mipsExecPkg::functSrl, mipsExecPkg::functSra,
        mipsExecPkg::functSllv, mipsExecPkg::functSrlv, mipsExecPkg::functSrav,
        mipsExecPkg::functMfhi, mipsExecPkg::functMflo,
        mipsExecPkg::functMult, mipsExecPkg::functMultu,
        mipsExecPkg::functDiv, mipsExecPkg::functDivu,
        mipsExecPkg::functAdd, mipsExecPkg::functAddu, mipsExecPkg::functSub,
        mipsExecPkg::functSubu, mipsExecPkg::functAnd, mipsExecPkg::functOr,
        mipsExecPkg::functXor, mipsExecPkg::functSlt, mipsExecPkg::functSltu,
        6'h3f
    };
    localparam mipsExecPkg::word_t cornerVals [0:4] = '{
        32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff
    };
    localparam mipsExecPkg::word_t mulDivVals [0:5] = '{
        32'h0, 32'h1, 32'h7, 32'hfffffff9, 32'h12345678, 32'h80000001
    };

    logic                clk;
    logic                reset;
    logic                valid;
    mipsExecPkg::funct_t funct;
    mipsExecPkg::shamt_t shamt;
    mipsExecPkg::word_t  rsData;
    mipsExecPkg::word_t  rtData;
    logic                resultValid;
    mipsExecPkg::word_t  result;
    logic                zero;
    mipsExecPkg::word_t  hi;
    mipsExecPkg::word_t  lo;
    int                  errorCount;
    int                  inFlight;
    int                  timeouts = 0;
    int                  seed = 32'h655d5206;

    execStage uut (.clk(clk), .reset(reset), .valid(valid), .funct(funct), .shamt(shamt),
        .rsData(rsData), .rtData(rtData), .resultValid(resultValid), .result(result),
        .zero(zero), .hi(hi), .lo(lo));

    execStageChecker scoreboard (.clk(clk), .reset(reset), .valid(valid), .funct(funct),
        .shamt(shamt), .rsData(rsData), .rtData(rtData), .resultValid(resultValid),
        .result(result), .zero(zero), .hi(hi), .lo(lo), .errorCount(errorCount),
        .inFlight(inFlight));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic issue(input mipsExecPkg::funct_t f, input mipsExecPkg::shamt_t sa,
                         input mipsExecPkg::word_t rs, input mipsExecPkg::word_t rt);
        @(posedge clk);
        valid  <= 1'b1;
        funct  <= f;
        shamt  <= sa;
        rsData <= rs;
        rtData <= rt;
    endtask

    task automatic drain;
        int waited;
        @(posedge clk);
        valid  <= 1'b0;
        waited = 0;
        @(negedge clk);                 // checker counts are settled here
        while (inFlight != 0 && waited < 20) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (inFlight != 0) begin
            timeouts = timeouts + 1;
            $display("pipeline still had %0d instructions after 20 cycles", inFlight);
        end
    endtask

    initial begin
        mipsExecPkg::shamt_t amt;
        mipsExecPkg::shamt_t rsLow;
        mipsExecPkg::shamt_t fieldSa;
        mipsExecPkg::word_t  a;
        mipsExecPkg::word_t  b;
        int                  k;
        reset  = 1'b1;
        valid  = 1'b0;
        funct  = '0;
        shamt  = '0;
        rsData = '0;
        rtData = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int f = 12; f <= 20; f++)           // logic, arith, compare corners
            for (int i = 0; i < 5; i++)
                for (int j = 0; j < 5; j++)
                    issue(functList[f], 5'd0, cornerVals[i], cornerVals[j]);
        drain();
        for (int f = 0; f <= 5; f++) begin       // all six shifts
            for (int i = 0; i < 4; i++) begin
                amt = (i == 0) ? 5'd0 : (i == 1) ? 5'd1 : (i == 2) ? 5'd31 :
                      mipsExecPkg::shamt_t'($random(seed));
                rsLow   = (f >= 3) ? amt : ~amt;     // other field differs
                fieldSa = (f >= 3) ? ~amt : amt;
                a = {27'h7ffffe0 ^ 27'($random(seed)), rsLow};   // high bits in rs
                issue(functList[f], fieldSa, a, 32'h80000001);
                issue(functList[f], fieldSa, a, 32'hf0f0f0f0);
                issue(functList[f], fieldSa, a, $random(seed));
            end
        end
        drain();
        for (int f = 8; f <= 11; f++)            // mult/div then moves right behind
            for (int i = 0; i < 6; i++)
                for (int j = 0; j < 6; j++) begin
                    issue(functList[f], 5'd0, mulDivVals[i], mulDivVals[j]);
                    issue(mipsExecPkg::functMfhi, 5'd0, 32'h0, 32'h0);
                    issue(mipsExecPkg::functMflo, 5'd0, 32'h0, 32'h0);
                end
        drain();
        issue(mipsExecPkg::functMult, 5'd0, 32'h12345678, 32'h9abcdef0);
        for (int i = 0; i < 8; i++) begin        // unknown codes keep hi/lo
            a = $random(seed);
            issue((i % 3 == 0) ? 6'h01 : (i % 3 == 1) ? 6'h3f : 6'h2c, 5'd3, a,
                  i[0] ? a : $random(seed));
        end
        issue(mipsExecPkg::functMfhi, 5'd0, 32'h0, 32'h0);
        issue(mipsExecPkg::functMflo, 5'd0, 32'h0, 32'h0);
        drain();
        for (int i = 0; i < 2000; i++) begin     // mixed random sequence
            k = $unsigned($random(seed)) % 22;
            a = $random(seed);
            b = (($random(seed) & 3) == 0) ? a : $random(seed);
            issue(functList[k], mipsExecPkg::shamt_t'($random(seed)), a, b);
            if (($random(seed) & 7) == 0) begin
                @(posedge clk);
                valid <= 1'b0;
            end
        end
        drain();
        $display("checks done: %0d errors, %0d timeouts", errorCount, timeouts);
        if (errorCount == 0 && timeouts == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/execStage_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module execStageChk (
    input wire                      clk,
    input wire                      reset,
    input wire                      valid,
    input wire mipsExecPkg::funct_t funct,
    input wire                      resultValid,
    input wire mipsExecPkg::word_t  hi,
    input wire mipsExecPkg::word_t  lo
);

    logic [1:0] quietCycles;   // edges since reset release, saturating
    logic       mulDivIssued;

    assign mulDivIssued = valid && (funct == mipsExecPkg::functMult ||
                                    funct == mipsExecPkg::functMultu ||
                                    funct == mipsExecPkg::functDiv ||
                                    funct == mipsExecPkg::functDivu);

    always_ff @(posedge clk) begin
        if (reset) begin
            quietCycles <= 2'd0;
        end else if (quietCycles != 2'd3) begin
            quietCycles <= quietCycles + 2'd1;
        end
    end

    resultLatency: assert property (@(posedge clk)
        (quietCycles >= 2'd2) |-> (resultValid == $past(valid, 2)))
        else $error("resultValid did not follow valid by exactly two cycles");

    resetQuiet: assert property (@(posedge clk)
        ($past(reset) || $past(reset, 2)) |-> !resultValid)
        else $error("resultValid was high during reset or right after it");

    hiLoHold: assert property (@(posedge clk)
        (quietCycles == 2'd3 && !$past(mulDivIssued, 2)) |-> ($stable(hi) && $stable(lo)))
        else $error("hi or lo changed without a multiply or divide");

endmodule

bind execStage execStageChk chk (
    .clk(clk),
    .reset(reset),
    .valid(valid),
    .funct(funct),
    .resultValid(resultValid),
    .hi(hi),
    .lo(lo)
);

`default_nettype wire

// ==== sim/execStageChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module execStageChecker (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       valid,
    input  wire mipsExecPkg::funct_t  funct,
    input  wire mipsExecPkg::shamt_t  shamt,
    input  wire mipsExecPkg::word_t   rsData,
    input  wire mipsExecPkg::word_t   rtData,
    input  wire                       resultValid,
    input  wire mipsExecPkg::word_t   result,
    input  wire                       zero,
    input  wire mipsExecPkg::word_t   hi,
    input  wire mipsExecPkg::word_t   lo,
    output int                        errorCount,
    output int                        inFlight
);

    logic [74:0]        issueQ [$];      // funct, shamt, rs, rt
    int                 issueCycle [$];
    mipsExecPkg::word_t modelHi;
    mipsExecPkg::word_t modelLo;
    int                 cycle = 0;
    int                 errors = 0;
    int                 pendingCount = 0;

    assign errorCount = errors;
    assign inFlight   = pendingCount;

    // expected {result, zero, hi, lo} for one instruction
    function automatic logic [96:0] expectedOutputs(
        input logic [5:0]  f,
        input logic [4:0]  sa,
        input logic [31:0] rs,
        input logic [31:0] rt,
        input logic [31:0] hiIn,
        input logic [31:0] loIn
    );
        logic [31:0]        res;
        logic [31:0]        hiOut;
        logic [31:0]        loOut;
        logic [63:0]        wide;
        logic signed [63:0] sRs;
        logic signed [63:0] sRt;
        res   = 32'h0;
        hiOut = hiIn;
        loOut = loIn;
        sRs   = {{32{rs[31]}}, rs};
        sRt   = {{32{rt[31]}}, rt};
        case (f)
            mipsExecPkg::functAnd:  res = rs & rt;
            mipsExecPkg::functOr:   res = rs | rt;
            mipsExecPkg::functXor:  res = rs ^ rt;
            mipsExecPkg::functAdd,
            mipsExecPkg::functAddu: res = rs + rt;
            mipsExecPkg::functSub,
            mipsExecPkg::functSubu: res = rs - rt;
            mipsExecPkg::functSlt:  res = {31'h0, sRs < sRt};
            mipsExecPkg::functSltu: res = {31'h0, rs < rt};
            mipsExecPkg::functSll:  res = rt << sa;
            mipsExecPkg::functSllv: res = rt << rs[4:0];
            mipsExecPkg::functSrl:  res = rt >> sa;
            mipsExecPkg::functSrlv: res = rt >> rs[4:0];
            mipsExecPkg::functSra: begin
                wide = {{32{rt[31]}}, rt} >> sa;   // sign bits shift in from above
                res  = wide[31:0];
            end
            mipsExecPkg::functSrav: begin
                wide = {{32{rt[31]}}, rt} >> rs[4:0];
                res  = wide[31:0];
            end
            mipsExecPkg::functMult: begin
                wide           = sRs * sRt;
                {hiOut, loOut} = wide;
            end
            mipsExecPkg::functMultu: begin
                wide           = {32'h0, rs} * {32'h0, rt};
                {hiOut, loOut} = wide;
            end
            mipsExecPkg::functDiv: begin
                if (rt == 32'h0) begin
                    loOut = 32'hffffffff;
                    hiOut = rs;
                end else begin
                    wide  = sRs / sRt;   // 64-bit form, no overflow
                    loOut = wide[31:0];
                    wide  = sRs % sRt;
                    hiOut = wide[31:0];
                end
            end
            mipsExecPkg::functDivu: begin
                loOut = (rt == 32'h0) ? 32'hffffffff : rs / rt;
                hiOut = (rt == 32'h0) ? rs : rs % rt;
            end
            mipsExecPkg::functMfhi: res = hiIn;
            mipsExecPkg::functMflo: res = loIn;
            default: ;                               // unknown code changes nothing
        endcase
        return {res, rs == rt, hiOut, loOut};
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp, input logic [5:0] f);
        if (got !== exp) begin
            errors = errors + 1;
            $display("ERROR %s: got %h expected %h (funct %h)", name, got, exp, f);
        end
    endtask

    always @(posedge clk) begin
        logic [74:0] entry;
        logic [96:0] expected;
        int          latency;
        cycle = cycle + 1;
        if (reset) begin
            issueQ.delete();
            issueCycle.delete();
            modelHi = 32'h0;
            modelLo = 32'h0;
        end else begin
            if (resultValid) begin
                if (issueQ.size() == 0) begin
                    errors = errors + 1;
                    $display("resultValid was high with no instruction in flight");
                end else begin
                    entry    = issueQ.pop_front();
                    latency  = cycle - issueCycle.pop_front();
                    expected = expectedOutputs(entry[74:69], entry[68:64], entry[63:32],
                                               entry[31:0], modelHi, modelLo);
                    if (latency != 2) begin
                        errors = errors + 1;
                        $display("funct %h finished after %0d cycles instead of 2",
                                 entry[74:69], latency);
                    end
                    reportMismatch("result", result, expected[96:65], entry[74:69]);
                    reportMismatch("zero", {31'h0, zero}, {31'h0, expected[64]}, entry[74:69]);
                    reportMismatch("hi", hi, expected[63:32], entry[74:69]);
                    reportMismatch("lo", lo, expected[31:0], entry[74:69]);
                    modelHi = expected[63:32];
                    modelLo = expected[31:0];
                end
            end
            if (valid) begin
                issueQ.push_back({funct, shamt, rsData, rtData});
                issueCycle.push_back(cycle);
            end
        end
        pendingCount = issueQ.size();
    end

endmodule

`default_nettype wire

// ==== logic/execStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execStage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       valid,
    input  wire mipsExecPkg::funct_t  funct,
    input  wire mipsExecPkg::shamt_t  shamt,
    input  wire mipsExecPkg::word_t   rsData,
    input  wire mipsExecPkg::word_t   rtData,
    output logic                      resultValid,
    output mipsExecPkg::word_t        result,
    output logic                      zero,
    output mipsExecPkg::word_t        hi,
    output mipsExecPkg::word_t        lo
);

    logic                opValid;
    mipsExecPkg::aluOp_t aluOp;
    mipsExecPkg::shamt_t opShamt;
    mipsExecPkg::word_t  opA;
    mipsExecPkg::word_t  opB;
    mipsExecPkg::word_t  aluResult;

    functDecoder decoder (
        .clk(clk),
        .reset(reset),
        .valid(valid),
        .funct(funct),
        .shamt(shamt),
        .rsData(rsData),
        .rtData(rtData),
        .opValid(opValid),
        .aluOp(aluOp),
        .opShamt(opShamt),
        .opA(opA),
        .opB(opB)
    );

    aluCore alu (
        .aluOp(aluOp),
        .opShamt(opShamt),
        .opA(opA),
        .opB(opB),
        .aluResult(aluResult)
    );

    // hi/lo land on the same edge as the mult/div result
    mulDivUnit mulDiv (
        .clk(clk),
        .reset(reset),
        .opValid(opValid),
        .aluOp(aluOp),
        .opA(opA),
        .opB(opB),
        .hi(hi),
        .lo(lo)
    );

    resultStage outStage (
        .clk(clk),
        .reset(reset),
        .opValid(opValid),
        .aluOp(aluOp),
        .aluResult(aluResult),
        .hi(hi),
        .lo(lo),
        .opA(opA),
        .opB(opB),
        .resultValid(resultValid),
        .result(result),
        .zero(zero)
    );

endmodule

`default_nettype wire

// ==== logic/resultStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultStage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       opValid,
    input  wire mipsExecPkg::aluOp_t  aluOp,
    input  wire mipsExecPkg::word_t   aluResult,
    input  wire mipsExecPkg::word_t   hi,
    input  wire mipsExecPkg::word_t   lo,
    input  wire mipsExecPkg::word_t   opA,
    input  wire mipsExecPkg::word_t   opB,
    output logic                      resultValid,
    output mipsExecPkg::word_t        result,
    output logic                      zero
);

    mipsExecPkg::word_t selResult;

    // aluResult is already zero for mult, div and unknown codes
    always_comb begin
        case (aluOp)
            mipsExecPkg::opMfhi: selResult = hi;
            mipsExecPkg::opMflo: selResult = lo;
            default:             selResult = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            result      <= '0;
            zero        <= 1'b0;
        end else begin
            resultValid <= opValid;
            if (opValid) begin
                result <= selResult;
                zero   <= (opA == opB);  // branch equality
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mulDivUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mulDivUnit (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       opValid,
    input  wire mipsExecPkg::aluOp_t  aluOp,
    input  wire mipsExecPkg::word_t   opA,
    input  wire mipsExecPkg::word_t   opB,
    output mipsExecPkg::word_t        hi,
    output mipsExecPkg::word_t        lo
);

    logic signed [31:0] signedA;
    logic signed [31:0] signedB;
    logic signed [63:0] prodSigned;
    logic        [63:0] prodUnsigned;
    mipsExecPkg::word_t quotSigned;
    mipsExecPkg::word_t remSigned;
    mipsExecPkg::word_t quotUnsigned;
    mipsExecPkg::word_t remUnsigned;
    logic               divByZero;

    assign signedA      = opA;
    assign signedB      = opB;
    assign prodSigned   = signedA * signedB;   // operands sign extended to 64
    assign prodUnsigned = opA * opB;           // zero extended
    assign divByZero    = (opB == '0);

    always_comb begin
        if (divByZero) begin
            quotSigned   = '1;   // all ones quotient
            remSigned    = opA;  // remainder keeps the dividend
            quotUnsigned = '1;
            remUnsigned  = opA;
        end else begin
            quotSigned   = signedA / signedB;
            remSigned    = signedA % signedB;  // sign follows dividend
            quotUnsigned = opA / opB;
            remUnsigned  = opA % opB;
        end
    end

    // only multiply and divide write hi/lo
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (opValid) begin
            case (aluOp)
                mipsExecPkg::opMult:  {hi, lo} <= prodSigned;    // upper half to hi
                mipsExecPkg::opMultu: {hi, lo} <= prodUnsigned;
                mipsExecPkg::opDiv: begin
                    hi <= remSigned;
                    lo <= quotSigned;
                end
                mipsExecPkg::opDivu: begin
                    hi <= remUnsigned;
                    lo <= quotUnsigned;
                end
                default: ;  // hold
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/aluCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluCore (
    input  wire mipsExecPkg::aluOp_t  aluOp,
    input  wire mipsExecPkg::shamt_t  opShamt,
    input  wire mipsExecPkg::word_t   opA,
    input  wire mipsExecPkg::word_t   opB,
    output mipsExecPkg::word_t        aluResult
);

    logic signed [31:0] signedA;
    logic signed [31:0] signedB;
    logic signed [31:0] sraResult;

    assign signedA = opA;
    assign signedB = opB;

    // sign bits fill from the left
    assign sraResult = signedB >>> opShamt;

    // variable shifts already carry rs[4:0] in opShamt
    always_comb begin
        case (aluOp)
            mipsExecPkg::opAnd: begin
                aluResult = opA & opB;
            end
            mipsExecPkg::opOr: begin
                aluResult = opA | opB;
            end
            mipsExecPkg::opXor: begin
                aluResult = opA ^ opB;
            end
            mipsExecPkg::opAdd: begin
                aluResult = opA + opB;  // wraps, no trap
            end
            mipsExecPkg::opSub: begin
                aluResult = opA - opB;
            end
            mipsExecPkg::opSlt: begin
                aluResult = (signedA < signedB) ? 32'd1 : 32'd0;
            end
            mipsExecPkg::opSltu: begin
                aluResult = (opA < opB) ? 32'd1 : 32'd0;
            end
            mipsExecPkg::opSll: begin
                aluResult = opB << opShamt;
            end
            mipsExecPkg::opSrl: begin
                aluResult = opB >> opShamt;
            end
            mipsExecPkg::opSra: begin
                aluResult = sraResult;
            end
            // mult, div, moves and unknown codes produce nothing here
            default: begin
                aluResult = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/functDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module functDecoder (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       valid,
    input  wire mipsExecPkg::funct_t  funct,
    input  wire mipsExecPkg::shamt_t  shamt,
    input  wire mipsExecPkg::word_t   rsData,
    input  wire mipsExecPkg::word_t   rtData,
    output logic                      opValid,
    output mipsExecPkg::aluOp_t       aluOp,
    output mipsExecPkg::shamt_t       opShamt,
    output mipsExecPkg::word_t        opA,
    output mipsExecPkg::word_t        opB
);

    mipsExecPkg::aluOp_t decodedOp;
    logic                varShift;   // shift amount comes from rs

    always_comb begin
        decodedOp = mipsExecPkg::opNone;
        varShift  = 1'b0;
        case (funct)
            mipsExecPkg::functAnd:   decodedOp = mipsExecPkg::opAnd;
            mipsExecPkg::functOr:    decodedOp = mipsExecPkg::opOr;
            mipsExecPkg::functXor:   decodedOp = mipsExecPkg::opXor;
            mipsExecPkg::functAdd,
            mipsExecPkg::functAddu:  decodedOp = mipsExecPkg::opAdd;  // no overflow trap
            mipsExecPkg::functSub,
            mipsExecPkg::functSubu:  decodedOp = mipsExecPkg::opSub;
            mipsExecPkg::functSlt:   decodedOp = mipsExecPkg::opSlt;
            mipsExecPkg::functSltu:  decodedOp = mipsExecPkg::opSltu;
            mipsExecPkg::functSll:   decodedOp = mipsExecPkg::opSll;
            mipsExecPkg::functSrl:   decodedOp = mipsExecPkg::opSrl;
            mipsExecPkg::functSra:   decodedOp = mipsExecPkg::opSra;
            mipsExecPkg::functSllv: begin
                decodedOp = mipsExecPkg::opSll;
                varShift  = 1'b1;
            end
            mipsExecPkg::functSrlv: begin
                decodedOp = mipsExecPkg::opSrl;
                varShift  = 1'b1;
            end
            mipsExecPkg::functSrav: begin
                decodedOp = mipsExecPkg::opSra;
                varShift  = 1'b1;
            end
            mipsExecPkg::functMult:  decodedOp = mipsExecPkg::opMult;
            mipsExecPkg::functMultu: decodedOp = mipsExecPkg::opMultu;
            mipsExecPkg::functDiv:   decodedOp = mipsExecPkg::opDiv;
            mipsExecPkg::functDivu:  decodedOp = mipsExecPkg::opDivu;
            mipsExecPkg::functMfhi:  decodedOp = mipsExecPkg::opMfhi;
            mipsExecPkg::functMflo:  decodedOp = mipsExecPkg::opMflo;
            default:                 decodedOp = mipsExecPkg::opNone;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opValid <= 1'b0;
        end else begin
            opValid <= valid;  // one-cycle strobe per instruction
        end
    end

    // instruction register, loaded only on a new instruction
    always_ff @(posedge clk) begin
        if (valid) begin
            aluOp   <= decodedOp;
            opShamt <= varShift ? rsData[4:0] : shamt;  // low five bits of rs
            opA     <= rsData;
            opB     <= rtData;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mipsExecPkg.sv ====
`default_nettype none

package mipsExecPkg;

    typedef logic [31:0] word_t;   // operand or result word
    typedef logic [4:0]  shamt_t;  // shift amount
    typedef logic [5:0]  funct_t;  // R-type function field
    typedef logic [4:0]  aluOp_t;  // internal operation code

    // standard MIPS function field values
    localparam funct_t functSll   = 6'h00;
    localparam funct_t functSrl   = 6'h02;
    localparam funct_t functSra   = 6'h03;
    localparam funct_t functSllv  = 6'h04;
    localparam funct_t functSrlv  = 6'h06;
    localparam funct_t functSrav  = 6'h07;
    localparam funct_t functMfhi  = 6'h10;
    localparam funct_t functMflo  = 6'h12;
    localparam funct_t functMult  = 6'h18;
    localparam funct_t functMultu = 6'h19;
    localparam funct_t functDiv   = 6'h1a;
    localparam funct_t functDivu  = 6'h1b;
    localparam funct_t functAdd   = 6'h20;
    localparam funct_t functAddu  = 6'h21;
    localparam funct_t functSub   = 6'h22;
    localparam funct_t functSubu  = 6'h23;
    localparam funct_t functAnd   = 6'h24;
    localparam funct_t functOr    = 6'h25;
    localparam funct_t functXor   = 6'h26;
    localparam funct_t functSlt   = 6'h2a;
    localparam funct_t functSltu  = 6'h2b;

    // operation codes keep the ALU control numbering where one exists
    localparam aluOp_t opAnd   = 5'd0;
    localparam aluOp_t opOr    = 5'd1;
    localparam aluOp_t opAdd   = 5'd2;   // add and addu
    localparam aluOp_t opDiv   = 5'd3;
    localparam aluOp_t opDivu  = 5'd4;
    localparam aluOp_t opXor   = 5'd5;
    localparam aluOp_t opSub   = 5'd6;   // sub and subu
    localparam aluOp_t opSlt   = 5'd7;
    localparam aluOp_t opSltu  = 5'd8;
    localparam aluOp_t opSll   = 5'd9;
    localparam aluOp_t opSrl   = 5'd10;
    localparam aluOp_t opMult  = 5'd11;
    localparam aluOp_t opMultu = 5'd12;
    localparam aluOp_t opSra   = 5'd15;
    localparam aluOp_t opMfhi  = 5'd17;
    localparam aluOp_t opMflo  = 5'd18;
    localparam aluOp_t opNone  = 5'd31;  // unknown function code

endpackage

`default_nettype wire
